/* hdl/uart_config.svh */
//##############################
// build-time constants of the UART peripheral
// rate is clocks per bit, a multiple of 16 and at least 32
// FIFO depth must be a power of two up to 8
//##############################
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

`define UART_FIFO_DEPTH   8
`define UART_DEFAULT_RATE 64 // short bits keep simulation fast
`define UART_OVERSAMPLE   16

`define UART_ADDR_RX_DATA  0
`define UART_ADDR_TX_DATA  4
`define UART_ADDR_RX_STATE 8
`define UART_ADDR_TX_STATE 12
`define UART_ADDR_BAUD     16
`define UART_ADDR_CLEAR    20

`endif

/* hdl/uartPkg.sv */
//##############################
// shared types of the UART peripheral
// fifoCount_t needs one bit more than the FIFO index
//##############################
package uartPkg;

  typedef logic [7:0]  uartByte_t;
  typedef logic [15:0] baudRate_t;  // clocks per bit
  typedef logic [3:0]  fifoCount_t; // 0..8
  typedef logic [7:0]  regAddr_t;
  typedef logic [31:0] regWord_t;

  // one bus cycle, strobes are single-cycle
  typedef struct packed {
    regAddr_t addr;
    logic     wen;
    logic     ren;
    regWord_t wdata;
  } busReq_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } txState_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rxState_t;

endpackage

/* hdl/byteFifo.sv */
//##############################
// circular byte FIFO
// push when full and pop when empty are dropped
//##############################
`timescale 1ns/1ps
`include "uart_config.svh"

module byteFifo import uartPkg::*; (
  input  logic       clk,
  input  logic       nReset,
  input  logic       push,
  input  uartByte_t  pushData,
  input  logic       pop,
  input  logic       clear,
  output uartByte_t  head,
  output logic       full,
  output logic       empty,
  output fifoCount_t count
);

  localparam int PTR_W = $clog2(`UART_FIFO_DEPTH);

  uartByte_t mem [`UART_FIFO_DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic doPush;
  logic doPop;

  assign full   = (count == fifoCount_t'(`UART_FIFO_DEPTH));
  assign empty  = (count == '0);
  assign doPush = push && !full;
  assign doPop  = pop && !empty;
  assign head   = mem[rdPtr];

  always_ff @(posedge clk or negedge nReset) begin
    if (!nReset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else if (clear) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) wrPtr <= wrPtr + 1'b1; // wraps at the power-of-two depth
      if (doPop) rdPtr <= rdPtr + 1'b1;
      case ({doPush, doPop})
        2'b10:   count <= count + fifoCount_t'(1);
        2'b01:   count <= count - fifoCount_t'(1);
        default: count <= count; // both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (doPush && !clear) mem[wrPtr] <= pushData;
  end

endmodule

/* hdl/baudGen.sv */
//##############################
// bit and 16x sample tick generator
// rate must be a multiple of the oversample factor
//##############################
`timescale 1ns/1ps
`include "uart_config.svh"

module baudGen import uartPkg::*; (
  input  logic      clk,
  input  logic      nReset,
  input  baudRate_t rate,
  input  logic      rateLoad,
  output logic      bitTick,
  output logic      sampleTick
);

  baudRate_t bitCnt;
  baudRate_t sampleCnt;
  baudRate_t sampleRate;

  assign sampleRate = rate / baudRate_t'(`UART_OVERSAMPLE);
  assign bitTick    = (bitCnt == '0);
  assign sampleTick = (sampleCnt == '0);

  always_ff @(posedge clk or negedge nReset) begin
    if (!nReset) begin
      bitCnt    <= baudRate_t'(`UART_DEFAULT_RATE - 1);
      sampleCnt <= baudRate_t'(`UART_DEFAULT_RATE / `UART_OVERSAMPLE - 1);
    end else if (rateLoad) begin
      // restart both so the ticks stay aligned
      bitCnt    <= rate - baudRate_t'(1);
      sampleCnt <= sampleRate - baudRate_t'(1);
    end else begin
      bitCnt    <= bitTick ? rate - baudRate_t'(1) : bitCnt - baudRate_t'(1);
      sampleCnt <= sampleTick ? sampleRate - baudRate_t'(1) : sampleCnt - baudRate_t'(1);
    end
  end

endmodule

/* hdl/uartTx.sv */
//##############################
// 8N1 transmitter, one bit per bitTick
// next byte is taken back to back from the stop bit
//##############################
`timescale 1ns/1ps

module uartTx import uartPkg::*; (
  input  logic      clk,
  input  logic      nReset,
  input  logic      bitTick,
  input  uartByte_t head,
  input  logic      empty,
  output logic      pop,
  output logic      tx,
  output logic      busy
);

  txState_t state;
  uartByte_t shiftReg;
  logic [2:0] bitCnt;
  logic loadNext;

  // frame boundary with a byte waiting
  assign loadNext = bitTick && !empty && (state == TX_IDLE || state == TX_STOP);
  assign pop      = loadNext;
  assign busy     = (state != TX_IDLE);

  always_comb begin
    case (state)
      TX_START: tx = 1'b0;
      TX_DATA:  tx = shiftReg[0]; // LSB first
      default:  tx = 1'b1;        // idle and stop are mark level
    endcase
  end

  always_ff @(posedge clk or negedge nReset) begin
    if (!nReset) begin
      state  <= TX_IDLE;
      bitCnt <= '0;
    end else if (bitTick) begin
      case (state)
        TX_IDLE: begin
          if (!empty) state <= TX_START;
        end
        TX_START: begin
          state  <= TX_DATA;
          bitCnt <= '0;
        end
        TX_DATA: begin
          bitCnt <= bitCnt + 3'd1;
          if (bitCnt == 3'd7) state <= TX_STOP;
        end
        TX_STOP: begin
          state <= empty ? TX_IDLE : TX_START;
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (loadNext) begin
      shiftReg <= head;
    end else if (bitTick && state == TX_DATA) begin
      shiftReg <= {1'b0, shiftReg[7:1]};
    end
  end

endmodule

/* hdl/uartRx.sv */
//##############################
// oversampling 8N1 receiver
// samples at mid-bit, no resync inside a frame
// done and err are one-cycle pulses at mid stop bit
//##############################
`timescale 1ns/1ps
`include "uart_config.svh"

module uartRx import uartPkg::*; (
  input  logic      clk,
  input  logic      nReset,
  input  logic      sampleTick,
  input  logic      rx,
  output uartByte_t data,
  output logic      done,
  output logic      err
);

  localparam logic [3:0] MID_TICK  = 4'(`UART_OVERSAMPLE / 2 - 1);
  localparam logic [3:0] LAST_TICK = 4'(`UART_OVERSAMPLE - 1);

  rxState_t state;
  logic rxMeta;
  logic rxSync;
  logic rxPrev;
  logic [3:0] tickCnt;
  logic [2:0] bitCnt;
  logic fallEdge;

  assign fallEdge = rxPrev && !rxSync;

  // two-flop synchroniser plus edge history
  always_ff @(posedge clk or negedge nReset) begin
    if (!nReset) begin
      rxMeta <= 1'b1;
      rxSync <= 1'b1;
      rxPrev <= 1'b1;
    end else begin
      rxMeta <= rx;
      rxSync <= rxMeta;
      rxPrev <= rxSync;
    end
  end

  always_ff @(posedge clk or negedge nReset) begin
    if (!nReset) begin
      state   <= RX_IDLE;
      tickCnt <= '0;
      bitCnt  <= '0;
      done    <= 1'b0;
      err     <= 1'b0;
    end else begin
      done <= 1'b0;
      err  <= 1'b0;
      case (state)
        RX_IDLE: begin
          if (fallEdge) begin
            state   <= RX_START;
            tickCnt <= '0;
          end
        end
        RX_START: begin
          if (sampleTick) begin
            tickCnt <= tickCnt + 4'd1;
            if (tickCnt == MID_TICK) begin
              // still low at mid start bit, else a glitch
              state   <= rxSync ? RX_IDLE : RX_DATA;
              tickCnt <= '0;
              bitCnt  <= '0;
            end
          end
        end
        RX_DATA: begin
          if (sampleTick) begin
            tickCnt <= tickCnt + 4'd1; // wraps to 0 after the sample
            if (tickCnt == LAST_TICK) begin
              bitCnt <= bitCnt + 3'd1;
              if (bitCnt == 3'd7) state <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (sampleTick) begin
            tickCnt <= tickCnt + 4'd1;
            if (tickCnt == LAST_TICK) begin
              done  <= rxSync;
              err   <= !rxSync; // framing error
              state <= RX_IDLE;
            end
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // data shifts in LSB first, held until the next frame
  always_ff @(posedge clk) begin
    if (state == RX_DATA && sampleTick && tickCnt == LAST_TICK) begin
      data <= {rxSync, data[7:1]};
    end
  end

endmodule

/* hdl/busRegs.sv */
//##############################
// register decoder of the UART
// rdata follows ren by one cycle, 0 when unmapped
// rateLoad lags the rate write by one cycle
//##############################
`timescale 1ns/1ps
`include "uart_config.svh"

module busRegs import uartPkg::*; (
  input  logic       clk,
  input  logic       nReset,
  input  busReq_t    bus,
  input  uartByte_t  rxHead,
  input  logic       rxEmpty,
  input  fifoCount_t rxCount,
  input  fifoCount_t txCount,
  input  logic       txBusy,
  input  logic       rxDone,
  input  logic       rxErr,
  output regWord_t   rdata,
  output logic       txPush,
  output uartByte_t  txPushData,
  output logic       rxPop,
  output logic       fifoClear,
  output baudRate_t  rate,
  output logic       rateLoad
);

  localparam regAddr_t ADDR_RX_DATA  = regAddr_t'(`UART_ADDR_RX_DATA);
  localparam regAddr_t ADDR_TX_DATA  = regAddr_t'(`UART_ADDR_TX_DATA);
  localparam regAddr_t ADDR_RX_STATE = regAddr_t'(`UART_ADDR_RX_STATE);
  localparam regAddr_t ADDR_TX_STATE = regAddr_t'(`UART_ADDR_TX_STATE);
  localparam regAddr_t ADDR_BAUD     = regAddr_t'(`UART_ADDR_BAUD);
  localparam regAddr_t ADDR_CLEAR    = regAddr_t'(`UART_ADDR_CLEAR);

  logic avail;
  logic err;
  logic rdRxData;
  logic rdRxState;

  assign rdRxData   = bus.ren && bus.addr == ADDR_RX_DATA;
  assign rdRxState  = bus.ren && bus.addr == ADDR_RX_STATE;
  assign txPush     = bus.wen && bus.addr == ADDR_TX_DATA;
  assign txPushData = bus.wdata[7:0];
  assign rxPop      = rdRxData; // FIFO ignores it when empty
  assign fifoClear  = bus.wen && bus.addr == ADDR_CLEAR && |bus.wdata;

  always_ff @(posedge clk or negedge nReset) begin
    if (!nReset) begin
      rate     <= baudRate_t'(`UART_DEFAULT_RATE);
      rateLoad <= 1'b0;
      avail    <= 1'b0;
      err      <= 1'b0;
    end else begin
      rateLoad <= 1'b0;
      if (bus.wen && bus.addr == ADDR_BAUD) begin
        rate     <= bus.wdata[15:0];
        rateLoad <= 1'b1; // counters pick up the new rate next cycle
      end
      // sticky bits, a new event wins over the clearing read
      avail <= rxDone || (avail && !rdRxData);
      err   <= rxErr || (err && !rdRxState);
    end
  end

  always_ff @(posedge clk or negedge nReset) begin
    if (!nReset) begin
      rdata <= '0;
    end else if (bus.ren) begin
      case (bus.addr)
        ADDR_RX_DATA:  rdata <= {24'b0, rxEmpty ? 8'h00 : rxHead};
        ADDR_RX_STATE: rdata <= {26'b0, err, avail, rxCount};
        ADDR_TX_STATE: rdata <= {rate, 11'b0, txBusy, txCount};
        default:       rdata <= '0;
      endcase
    end else begin
      rdata <= '0;
    end
  end

endmodule

/* hdl/uartTop.sv */
//##############################
// UART peripheral top, wiring only
// full flags of both FIFOs are not exported
//##############################
`timescale 1ns/1ps

module uartTop import uartPkg::*; (
  input  logic     clk,
  input  logic     nReset,
  input  busReq_t  bus,
  output regWord_t rdata,
  input  logic     rx,
  output logic     tx
);

  uartByte_t txPushData, txHead, rxHead, rxData;
  fifoCount_t txCount, rxCount;
  baudRate_t rate;
  logic txPush, txPop, txEmpty, txBusy;
  logic rxPop, rxEmpty, rxDone, rxErr;
  logic fifoClear, rateLoad, bitTick, sampleTick;

  busRegs u_busRegs (
    .clk, .nReset, .bus,
    .rxHead, .rxEmpty, .rxCount, .txCount, .txBusy, .rxDone, .rxErr,
    .rdata, .txPush, .txPushData, .rxPop, .fifoClear, .rate, .rateLoad
  );

  byteFifo txFifo (
    .clk, .nReset,
    .push(txPush), .pushData(txPushData), .pop(txPop), .clear(fifoClear),
    .head(txHead), .full(), .empty(txEmpty), .count(txCount)
  );

  // received bytes go straight in, dropped when full
  byteFifo rxFifo (
    .clk, .nReset,
    .push(rxDone), .pushData(rxData), .pop(rxPop), .clear(fifoClear),
    .head(rxHead), .full(), .empty(rxEmpty), .count(rxCount)
  );

  baudGen u_baudGen (.clk, .nReset, .rate, .rateLoad, .bitTick, .sampleTick);

  uartTx u_uartTx (
    .clk, .nReset, .bitTick, .head(txHead), .empty(txEmpty),
    .pop(txPop), .tx, .busy(txBusy)
  );

  uartRx u_uartRx (
    .clk, .nReset, .sampleTick, .rx, .data(rxData), .done(rxDone), .err(rxErr)
  );

endmodule

/* sim/uartTop_properties.sv */
//##############################
// assertions bound into uartTop
// pulse checks hold for rates of 32 and up
//##############################
`timescale 1ns/1ps
`include "uart_config.svh"

module uartTop_properties import uartPkg::*; (
  input logic       clk,
  input logic       nReset,
  input fifoCount_t txCount,
  input fifoCount_t rxCount,
  input logic       txBusy,
  input logic       tx,
  input logic       txPop,
  input logic       rxDone
);

  fifoBounds: assert property (@(posedge clk) disable iff (!nReset)
    txCount <= fifoCount_t'(`UART_FIFO_DEPTH) && rxCount <= fifoCount_t'(`UART_FIFO_DEPTH))
    else $error("FIFO count above depth");

  // line stays at mark level until a byte is taken
  idleHigh: assert property (@(posedge clk) disable iff (!nReset) !txBusy && !txPop |=> tx)
    else $error("tx left mark level without a FIFO pop");

  popPulse: assert property (@(posedge clk) disable iff (!nReset) txPop |=> !txPop)
    else $error("txPop longer than one cycle");

  donePulse: assert property (@(posedge clk) disable iff (!nReset) rxDone |=> !rxDone)
    else $error("rxDone longer than one cycle");

endmodule

bind uartTop uartTop_properties u_uartTopProps (
  .clk, .nReset, .txCount, .rxCount, .txBusy, .tx, .txPop, .rxDone
);

/* sim/tbUartTop.sv */
//##############################
// UART testbench, tx looped back to rx unless the serial driver is selected
// curRate must follow every BAUD_RATE write for the tx decoder
//##############################
`timescale 1ns/1ps
`include "uart_config.svh"

module tbUartTop import uartPkg::*; ();

  localparam int POLL_LIMIT  = 2000;  // register reads
  localparam int FRAME_LIMIT = 20000; // clock cycles

  logic clk, nReset, txLine, rxLine, drvLine, useDriver, modelAvail;
  busReq_t bus;
  regWord_t rdata, word;
  baudRate_t curRate;
  integer seed;
  int valueErrors, timeoutErrors, i;
  uartByte_t txExp[$];
  uartByte_t rxExp[$];

  assign rxLine = useDriver ? drvLine : txLine; // loopback mux

  uartTop u_uartTop (.clk, .nReset, .bus, .rdata, .rx(rxLine), .tx(txLine));

  always #50 clk = ~clk;

  function automatic regWord_t refState(logic isTx, fifoCount_t cnt, logic avail, logic err,
                                        logic busy, baudRate_t rate);
    return isTx ? {rate, 11'b0, busy, cnt} : {26'b0, err, avail, cnt};
  endfunction

  task automatic checkByte(uartByte_t got, uartByte_t exp, string what);
    if (got !== exp) begin
      valueErrors++;
      $display("[FAIL] time %0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkWord(regWord_t got, regWord_t exp, string what);
    if (got !== exp) begin
      valueErrors++;
      $display("[FAIL] time %0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkCount(fifoCount_t got, fifoCount_t exp, string what);
    if (got !== exp) begin
      valueErrors++;
      $display("[FAIL] time %0t: %s got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic finishRun();
    $display("error count: %0d wrong values, %0d timeouts", valueErrors, timeoutErrors);
    if (valueErrors == 0 && timeoutErrors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  endtask

  task automatic timedOut(string what);
    timeoutErrors++;
    $display("timeout while waiting for %s, the DUT stopped responding", what);
    finishRun();
  endtask

  task automatic busWrite(regAddr_t addr, regWord_t data);
    @(negedge clk);
    bus.addr  = addr;
    bus.wdata = data;
    bus.wen   = 1'b1;
    @(negedge clk);
    bus.wen   = 1'b0;
  endtask

  // rdata is registered, taken one cycle after ren
  task automatic busRead(regAddr_t addr, output regWord_t data);
    @(negedge clk);
    bus.addr = addr;
    bus.ren  = 1'b1;
    @(negedge clk);
    bus.ren  = 1'b0;
    data     = rdata;
  endtask

  task automatic pollReg(regAddr_t addr, regWord_t mask, regWord_t value, string what,
                         output regWord_t data);
    int n = 0;
    busRead(addr, data);
    while ((data & mask) != value) begin
      if (n >= POLL_LIMIT) timedOut(what);
      n++;
      busRead(addr, data);
    end
  endtask

  // a looped-back byte lands in the RX FIFO unless it is full
  task automatic sendTx(uartByte_t b);
    txExp.push_back(b);
    if (rxExp.size() < `UART_FIFO_DEPTH) rxExp.push_back(b);
    modelAvail = 1'b1;
    busWrite(`UART_ADDR_TX_DATA, {24'b0, b});
  endtask

  task automatic waitTxDrained();
    int n = 0;
    while (txExp.size() != 0) begin
      if (n >= FRAME_LIMIT) timedOut("frames on tx");
      n++;
      @(negedge clk);
    end
  endtask

  task automatic sendFrame(uartByte_t b, logic stopBit);
    logic [9:0] frame;
    frame = {stopBit, b, 1'b0};
    @(negedge clk);
    for (int k = 0; k < 10; k++) begin
      drvLine = frame[k];
      repeat (curRate) @(negedge clk);
    end
    drvLine = 1'b1;
    repeat (2 * curRate) @(negedge clk); // idle gap
  endtask

  task automatic drainRx(int n);
    regWord_t w;
    for (int k = 0; k < n; k++) begin
      busRead(`UART_ADDR_RX_DATA, w);
      checkByte(w[7:0], rxExp.pop_front(), "RX_DATA");
      modelAvail = 1'b0;
      busRead(`UART_ADDR_RX_STATE, w);
      checkCount(w[3:0], fifoCount_t'(rxExp.size()), "RX count");
      checkWord(w, refState(1'b0, fifoCount_t'(rxExp.size()), 1'b0, 1'b0, 1'b0, curRate),
                "RX_STATE after pop");
    end
  endtask

  task automatic decodeFrame();
    baudRate_t r;
    logic [9:0] bits;
    r = curRate;
    repeat (r / 2) @(negedge clk); // middle of start bit
    for (int k = 0; k < 10; k++) begin
      bits[k] = txLine;
      if (k < 9) repeat (r) @(negedge clk);
    end
    if (bits[0] !== 1'b0 || bits[9] !== 1'b1) begin
      valueErrors++;
      $display("[FAIL] time %0t: tx frame start %b stop %b", $time, bits[0], bits[9]);
    end
    if (txExp.size() == 0) begin
      valueErrors++;
      $display("[FAIL] time %0t: unexpected frame %h on tx", $time, bits[8:1]);
    end else begin
      checkByte(bits[8:1], txExp.pop_front(), "tx frame");
    end
  endtask

  initial begin : serialMonitor
    logic lastLine;
    lastLine = 1'b1;
    forever begin
      @(negedge clk);
      if (nReset && lastLine && !txLine) decodeFrame();
      lastLine = txLine;
    end
  end

  initial begin
    clk = 1'b0;
    nReset = 1'b0;
    bus = '0;
    drvLine = 1'b1;
    useDriver = 1'b0;
    modelAvail = 1'b0;
    seed = 32'h86a2;
    curRate = `UART_DEFAULT_RATE;
    valueErrors = 0;
    timeoutErrors = 0;
    repeat (8) @(negedge clk);
    nReset = 1'b1;

    busRead(`UART_ADDR_TX_STATE, word);
    checkWord(word, refState(1'b1, 0, 1'b0, 1'b0, 1'b0, curRate), "TX_STATE after reset");
    busRead(`UART_ADDR_RX_STATE, word);
    checkWord(word, refState(1'b0, 0, 1'b0, 1'b0, 1'b0, curRate), "RX_STATE after reset");

    // loopback at the default rate, then at rate 32
    for (int pass = 0; pass < 2; pass++) begin
      if (pass == 1) begin
        busWrite(`UART_ADDR_BAUD, 32);
        curRate = 32;
        busRead(`UART_ADDR_TX_STATE, word);
        checkWord(word, refState(1'b1, 0, 1'b0, 1'b0, 1'b0, curRate), "TX_STATE new rate");
      end
      for (i = 0; i < 6 - 3 * pass; i++) sendTx(uartByte_t'($random(seed)));
      waitTxDrained();
      pollReg(`UART_ADDR_TX_STATE, 32'h10, 0, "TX idle", word);
      checkWord(word, refState(1'b1, 0, 1'b0, 1'b0, 1'b0, curRate), "TX_STATE after frames");
      pollReg(`UART_ADDR_RX_STATE, 32'hf, rxExp.size(), "RX count", word);
      checkWord(word, refState(1'b0, fifoCount_t'(rxExp.size()), modelAvail, 1'b0, 1'b0,
                curRate), "RX_STATE after loopback");
      drainRx(rxExp.size());
    end

    // overflow of the RX FIFO, then clear
    for (i = 0; i < 10; i++) begin
      pollReg(`UART_ADDR_TX_STATE, 32'h8, 0, "TX FIFO space", word);
      sendTx(uartByte_t'($random(seed)));
    end
    waitTxDrained();
    pollReg(`UART_ADDR_TX_STATE, 32'h10, 0, "TX idle", word);
    pollReg(`UART_ADDR_RX_STATE, 32'hf, rxExp.size(), "RX count", word);
    checkWord(word, refState(1'b0, 8, 1'b1, 1'b0, 1'b0, curRate), "RX_STATE when full");
    drainRx(7);
    // slow bit clock keeps new TX bytes queued until the clear
    busWrite(`UART_ADDR_BAUD, 1024);
    curRate = 1024;
    for (i = 0; i < 3; i++)
      busWrite(`UART_ADDR_TX_DATA, {24'b0, uartByte_t'($random(seed))});
    busRead(`UART_ADDR_TX_STATE, word);
    checkCount(word[3:0], 3, "TX count before clear");
    busWrite(`UART_ADDR_CLEAR, 1);
    rxExp.delete();
    busRead(`UART_ADDR_RX_STATE, word);
    checkCount(word[3:0], 0, "RX count after clear");
    checkWord(word, refState(1'b0, 0, 1'b0, 1'b0, 1'b0, curRate), "RX_STATE after clear");
    busRead(`UART_ADDR_TX_STATE, word);
    checkCount(word[3:0], 0, "TX count after clear");
    busWrite(`UART_ADDR_BAUD, 32);
    curRate = 32;

    // framing error from the serial driver
    useDriver = 1'b1;
    sendFrame(uartByte_t'($random(seed)), 1'b0);
    pollReg(`UART_ADDR_RX_STATE, 32'h20, 32'h20, "framing error flag", word);
    checkCount(word[3:0], 0, "RX count after bad frame");
    checkWord(word, refState(1'b0, 0, 1'b0, 1'b1, 1'b0, curRate), "RX_STATE bad stop bit");
    busRead(`UART_ADDR_RX_STATE, word);
    checkWord(word, refState(1'b0, 0, 1'b0, 1'b0, 1'b0, curRate), "RX_STATE err cleared");

    finishRun();
  end

endmodule

/* sim.f */
+incdir+hdl
hdl/uartPkg.sv
hdl/byteFifo.sv
hdl/baudGen.sv
hdl/uartTx.sv
hdl/uartRx.sv
hdl/busRegs.sv
hdl/uartTop.sv
sim/uartTop_properties.sv
sim/tbUartTop.sv

/* Makefile */
TOP     ?= tbUartTop
LOG     ?= sim.log
VFLAGS  ?= --binary --assert
OBJ_DIR ?= obj_dir

SRCS := $(shell grep -v '^+' sim.f)
HDRS := hdl/uart_config.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): sim.f $(SRCS) $(HDRS)
	verilator $(VFLAGS) -f sim.f --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "Simulation completed successfully" $(LOG) || \
		(echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
